// File: logic/mcr3_ctrl_pkg.sv
//==========================================================================
// Shared constants and types for the three-player control block
// Joystick words carry only the 10 low bits of the host joystick
// Game codes 3 and up all map to GAME_OTHER and give idle ports
//==========================================================================

package mcr3_ctrl_pkg;

	// Joystick word layout
	localparam int JOY_W      = 10;
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE_A = 4;
	localparam int JOY_FIRE_B = 5;
	localparam int JOY_FIRE_C = 6;
	localparam int JOY_FIRE_D = 7;
	localparam int JOY_START  = 8;
	localparam int JOY_COIN   = 9;

	localparam int NUM_PLAYERS = 3;

	// Input ports and DIP bank
	localparam int PORT_W    = 8;
	localparam int DIP_COUNT = 8;
	localparam int DIP_AW    = $clog2(DIP_COUNT);

	// ioctl download indices
	localparam logic [7:0] IDX_ROM  = 8'd0;
	localparam logic [7:0] IDX_GAME = 8'd1;
	localparam logic [7:0] IDX_DIP  = 8'd254;

	// Reset hold after a load or a reset request
	localparam int               HOLD_W            = 11;
	localparam logic [HOLD_W-1:0] RESET_HOLD_CYCLES = 11'd1024;

	typedef enum logic [1:0] {
		GAME_RAMPAGE    = 2'd0,
		GAME_SARGE      = 2'd1,
		GAME_POWERDRIVE = 2'd2,
		GAME_OTHER      = 2'd3
	} game_t;

	typedef enum logic [1:0] {
		SEQ_NO_ROM,
		SEQ_LOADING,
		SEQ_HOLD,
		SEQ_RUN
	} seq_state_t;

endpackage

// File: logic/download_decoder.sv
//==========================================================================
// Decodes ioctl writes into the game code and the eight DIP bytes
// Only DIP addresses below DIP_COUNT are written, others are ignored
// game lags the game-code write strobe by two clock edges
//==========================================================================

`timescale 1ns/1ps

module download_decoder (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        ioctl_download,
	input  logic                        ioctl_wr,
	input  logic [7:0]                  ioctl_index,
	input  logic [24:0]                 ioctl_addr,
	input  logic [7:0]                  ioctl_dout,
	output mcr3_ctrl_pkg::game_t        game,
	output logic [7:0]                  dip0,
	output logic                        dip_service,
	output logic                        rom_download
);

	logic [7:0] game_code;
	logic [7:0] dip [mcr3_ctrl_pkg::DIP_COUNT];
	logic       dip_wr;
	logic       game_wr;

	assign game_wr = ioctl_wr && (ioctl_index == mcr3_ctrl_pkg::IDX_GAME);
	assign dip_wr  = ioctl_wr && (ioctl_index == mcr3_ctrl_pkg::IDX_DIP) &&
		(ioctl_addr < 25'(mcr3_ctrl_pkg::DIP_COUNT));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			game_code <= 8'd0;
			for (int i = 0; i < mcr3_ctrl_pkg::DIP_COUNT; i++) begin
				dip[i] <= 8'hff;
			end
		end else begin
			if (game_wr) begin
				game_code <= ioctl_dout;
			end
			if (dip_wr) begin
				dip[ioctl_addr[mcr3_ctrl_pkg::DIP_AW-1:0]] <= ioctl_dout;
			end
		end
	end

	// Code to game type, one register stage
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			game <= mcr3_ctrl_pkg::GAME_RAMPAGE;
		end else begin
			case (game_code)
				8'd0:    game <= mcr3_ctrl_pkg::GAME_RAMPAGE;
				8'd1:    game <= mcr3_ctrl_pkg::GAME_SARGE;
				8'd2:    game <= mcr3_ctrl_pkg::GAME_POWERDRIVE;
				default: game <= mcr3_ctrl_pkg::GAME_OTHER;
			endcase
		end
	end

	assign dip0         = dip[0];
	assign dip_service  = dip[1][0];
	assign rom_download = ioctl_download && (ioctl_index == mcr3_ctrl_pkg::IDX_ROM);

	// ROM data only arrives inside a download window
	a_rom_wr_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		(ioctl_wr && (ioctl_index == mcr3_ctrl_pkg::IDX_ROM)) |-> ioctl_download)
		else $error("ROM write strobe outside of a download");

endmodule

// File: logic/reset_sequencer.sv
//==========================================================================
// Game reset FSM driven by the ROM download and reset-request levels
// game_reset is high out of reset and stays high until a ROM has loaded
// A held reset_request keeps restarting the hold until it is released
//==========================================================================

`timescale 1ns/1ps

module reset_sequencer (
	input  logic clk_sys,
	input  logic reset,
	input  logic rom_download,
	input  logic reset_request,
	input  logic hold_done,
	output logic hold_start,
	output logic game_reset,
	output logic rom_loading
);

	mcr3_ctrl_pkg::seq_state_t state;
	mcr3_ctrl_pkg::seq_state_t state_next;
	logic                      rom_download_q;
	logic                      rom_rise;
	logic                      rom_fall;

	assign rom_rise = rom_download & ~rom_download_q;
	assign rom_fall = ~rom_download & rom_download_q;

	//==========================================================================
	// Next state and hold start
	//==========================================================================
	always_comb begin
		state_next = state;
		hold_start = 1'b0;
		case (state)
			mcr3_ctrl_pkg::SEQ_NO_ROM: begin
				if (rom_rise) begin
					state_next = mcr3_ctrl_pkg::SEQ_LOADING;
				end
			end
			mcr3_ctrl_pkg::SEQ_LOADING: begin
				if (rom_fall) begin
					state_next = mcr3_ctrl_pkg::SEQ_HOLD;
					hold_start = 1'b1;
				end
			end
			mcr3_ctrl_pkg::SEQ_HOLD: begin
				if (rom_rise) begin
					state_next = mcr3_ctrl_pkg::SEQ_LOADING;
				end else if (reset_request) begin
					hold_start = 1'b1;
				end else if (hold_done) begin
					state_next = mcr3_ctrl_pkg::SEQ_RUN;
				end
			end
			mcr3_ctrl_pkg::SEQ_RUN: begin
				if (rom_rise) begin
					state_next = mcr3_ctrl_pkg::SEQ_LOADING;
				end else if (reset_request) begin
					state_next = mcr3_ctrl_pkg::SEQ_HOLD;
					hold_start = 1'b1;
				end
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state          <= mcr3_ctrl_pkg::SEQ_NO_ROM;
			rom_download_q <= 1'b0;
			game_reset     <= 1'b1;
			rom_loading    <= 1'b0;
		end else begin
			state          <= state_next;
			rom_download_q <= rom_download;
			// Outputs follow the next state so they line up with state
			game_reset     <= (state_next != mcr3_ctrl_pkg::SEQ_RUN);
			rom_loading    <= (state_next == mcr3_ctrl_pkg::SEQ_LOADING);
		end
	end

	// A ROM download or a reset request always keeps the game in reset
	a_reset_on_request: assert property (@(posedge clk_sys) disable iff (reset)
		(rom_download || reset_request) |=> game_reset)
		else $error("Game left running during a download or reset request");

endmodule

// File: logic/reset_hold_timer.sv
//==========================================================================
// Hold countdown, reloaded with RESET_HOLD_CYCLES on every hold_start
// hold_done stays high once the count reaches zero
//==========================================================================

`timescale 1ns/1ps

module reset_hold_timer (
	input  logic clk_sys,
	input  logic reset,
	input  logic hold_start,
	output logic hold_done
);

	logic [mcr3_ctrl_pkg::HOLD_W-1:0] count;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			count <= mcr3_ctrl_pkg::RESET_HOLD_CYCLES;
		end else if (hold_start) begin
			count <= mcr3_ctrl_pkg::RESET_HOLD_CYCLES;
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	assign hold_done = (count == '0);

	// A wrap below zero would leave the reload range
	a_no_wrap: assert property (@(posedge clk_sys) disable iff (reset)
		count <= mcr3_ctrl_pkg::RESET_HOLD_CYCLES)
		else $error("Hold counter wrapped below zero");

endmodule

// File: logic/gear_shifter.sv
//==========================================================================
// Power Drive gear bits, one per player
// Each rising edge of a player's fire D toggles that player's gear
// game_reset clears both the gears and the edge history
//==========================================================================

`timescale 1ns/1ps

module gear_shifter (
	input  logic                                 clk_sys,
	input  logic                                 game_reset,
	input  logic [mcr3_ctrl_pkg::NUM_PLAYERS-1:0] fire_d,
	output logic [mcr3_ctrl_pkg::NUM_PLAYERS-1:0] gear
);

	logic [mcr3_ctrl_pkg::NUM_PLAYERS-1:0] fire_d_q;
	logic [mcr3_ctrl_pkg::NUM_PLAYERS-1:0] fire_rise;

	assign fire_rise = fire_d & ~fire_d_q;

	always_ff @(posedge clk_sys) begin
		if (game_reset) begin
			fire_d_q <= '0;
			gear     <= '0;
		end else begin
			fire_d_q <= fire_d;
			gear     <= gear ^ fire_rise;
		end
	end

endmodule

// File: logic/input_port_mux.sv
//==========================================================================
// Builds the five active-low input ports for the selected game
// Purely combinational, ports follow the inputs in the same cycle
// input3 is always DIP byte 0; unknown games read all ones elsewhere
//==========================================================================

`timescale 1ns/1ps

module input_port_mux (
	input  mcr3_ctrl_pkg::game_t                  game,
	input  logic [mcr3_ctrl_pkg::JOY_W-1:0]       joy1,
	input  logic [mcr3_ctrl_pkg::JOY_W-1:0]       joy2,
	input  logic [mcr3_ctrl_pkg::JOY_W-1:0]       joy3,
	input  logic                                  two_stick_mode,
	input  logic                                  sound_status,
	input  logic [7:0]                            dip0,
	input  logic                                  dip_service,
	input  logic [mcr3_ctrl_pkg::NUM_PLAYERS-1:0] gear,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0]      input0,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0]      input1,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0]      input2,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0]      input3,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0]      input4
);

	// Six-bit field: fire B, fire A, left, down, right, up
	function automatic logic [5:0] stick_fields(input logic [mcr3_ctrl_pkg::JOY_W-1:0] j);
		stick_fields = {j[mcr3_ctrl_pkg::JOY_FIRE_B], j[mcr3_ctrl_pkg::JOY_FIRE_A],
			j[mcr3_ctrl_pkg::JOY_LEFT], j[mcr3_ctrl_pkg::JOY_DOWN],
			j[mcr3_ctrl_pkg::JOY_RIGHT], j[mcr3_ctrl_pkg::JOY_UP]};
	endfunction

	// Sarge remap, returns {rd, ru, ld, lu}
	function automatic logic [3:0] sarge_sticks(input logic [mcr3_ctrl_pkg::JOY_W-1:0] j,
		input logic mode);
		logic u;
		logic d;
		logic l;
		logic r;
		u = j[mcr3_ctrl_pkg::JOY_UP];
		d = j[mcr3_ctrl_pkg::JOY_DOWN];
		l = j[mcr3_ctrl_pkg::JOY_LEFT];
		r = j[mcr3_ctrl_pkg::JOY_RIGHT];
		if (mode) begin
			sarge_sticks = {d | r, u | l, d | l, u | r};
		end else begin
			// Right stick falls back to fire B and fire C
			sarge_sticks = {j[mcr3_ctrl_pkg::JOY_FIRE_B], j[mcr3_ctrl_pkg::JOY_FIRE_C], d, u};
		end
	endfunction

	// Power Drive field: fire B, fire A, gear, fire C
	function automatic logic [3:0] drive_fields(input logic [mcr3_ctrl_pkg::JOY_W-1:0] j,
		input logic g);
		drive_fields = {j[mcr3_ctrl_pkg::JOY_FIRE_B], j[mcr3_ctrl_pkg::JOY_FIRE_A], g,
			j[mcr3_ctrl_pkg::JOY_FIRE_C]};
	endfunction

	always_comb begin
		input0 = 8'hff;
		input1 = 8'hff;
		input2 = 8'hff;
		input3 = dip0;
		input4 = 8'hff;
		case (game)
			mcr3_ctrl_pkg::GAME_RAMPAGE: begin
				input0 = ~{2'b00, dip_service, 3'b000,
					joy2[mcr3_ctrl_pkg::JOY_COIN], joy1[mcr3_ctrl_pkg::JOY_COIN]};
				input1 = ~{2'b00, stick_fields(joy1)};
				input2 = ~{2'b00, stick_fields(joy2)};
				input4 = ~{sound_status, 1'b0, stick_fields(joy3)};
			end
			mcr3_ctrl_pkg::GAME_SARGE: begin
				input0 = ~{2'b00, dip_service, 1'b0,
					joy2[mcr3_ctrl_pkg::JOY_START], joy1[mcr3_ctrl_pkg::JOY_START],
					joy2[mcr3_ctrl_pkg::JOY_COIN], joy1[mcr3_ctrl_pkg::JOY_COIN]};
				input1 = ~{{2{joy1[mcr3_ctrl_pkg::JOY_FIRE_D]}},
					{2{joy1[mcr3_ctrl_pkg::JOY_FIRE_A]}}, sarge_sticks(joy1, two_stick_mode)};
				input2 = ~{{2{joy2[mcr3_ctrl_pkg::JOY_FIRE_D]}},
					{2{joy2[mcr3_ctrl_pkg::JOY_FIRE_A]}}, sarge_sticks(joy2, two_stick_mode)};
			end
			mcr3_ctrl_pkg::GAME_POWERDRIVE: begin
				input0 = ~{2'b00, dip_service, 2'b00, joy3[mcr3_ctrl_pkg::JOY_COIN],
					joy2[mcr3_ctrl_pkg::JOY_COIN], joy1[mcr3_ctrl_pkg::JOY_COIN]};
				input1 = ~{drive_fields(joy2, gear[1]), drive_fields(joy1, gear[0])};
				input2 = ~{sound_status, 3'b000, drive_fields(joy3, gear[2])};
			end
			default: begin
				input0 = 8'hff;
			end
		endcase
	end

endmodule

// File: logic/mcr3_control_top.sv
//==========================================================================
// Control side of the three-player board: downloads, reset and inputs
// The game is held in reset until a ROM has been downloaded
// All inputs are assumed synchronous to clk_sys
//==========================================================================

`timescale 1ns/1ps

module mcr3_control_top (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  logic                             ioctl_download,
	input  logic                             ioctl_wr,
	input  logic [7:0]                       ioctl_index,
	input  logic [24:0]                      ioctl_addr,
	input  logic [7:0]                       ioctl_dout,
	input  logic                             reset_request,
	input  logic                             two_stick_mode,
	input  logic                             sound_status,
	input  logic [mcr3_ctrl_pkg::JOY_W-1:0]  joy1,
	input  logic [mcr3_ctrl_pkg::JOY_W-1:0]  joy2,
	input  logic [mcr3_ctrl_pkg::JOY_W-1:0]  joy3,
	output logic                             game_reset,
	output logic                             rom_loading,
	output mcr3_ctrl_pkg::game_t             game,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0] input0,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0] input1,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0] input2,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0] input3,
	output logic [mcr3_ctrl_pkg::PORT_W-1:0] input4
);

	logic [7:0]                            dip0;
	logic                                  dip_service;
	logic                                  rom_download;
	logic                                  hold_start;
	logic                                  hold_done;
	logic [mcr3_ctrl_pkg::NUM_PLAYERS-1:0] fire_d;
	logic [mcr3_ctrl_pkg::NUM_PLAYERS-1:0] gear;

	assign fire_d = {joy3[mcr3_ctrl_pkg::JOY_FIRE_D], joy2[mcr3_ctrl_pkg::JOY_FIRE_D],
		joy1[mcr3_ctrl_pkg::JOY_FIRE_D]};

	download_decoder u_download_decoder (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.game           (game),
		.dip0           (dip0),
		.dip_service    (dip_service),
		.rom_download   (rom_download)
	);

	reset_sequencer u_reset_sequencer (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.rom_download  (rom_download),
		.reset_request (reset_request),
		.hold_done     (hold_done),
		.hold_start    (hold_start),
		.game_reset    (game_reset),
		.rom_loading   (rom_loading)
	);

	reset_hold_timer u_reset_hold_timer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.hold_start (hold_start),
		.hold_done  (hold_done)
	);

	// Gears restart with every game reset
	gear_shifter u_gear_shifter (
		.clk_sys    (clk_sys),
		.game_reset (game_reset),
		.fire_d     (fire_d),
		.gear       (gear)
	);

	input_port_mux u_input_port_mux (
		.game           (game),
		.joy1           (joy1),
		.joy2           (joy2),
		.joy3           (joy3),
		.two_stick_mode (two_stick_mode),
		.sound_status   (sound_status),
		.dip0           (dip0),
		.dip_service    (dip_service),
		.gear           (gear),
		.input0         (input0),
		.input1         (input1),
		.input2         (input2),
		.input3         (input3),
		.input4         (input4)
	);

endmodule

// File: test/tb_mcr3_control.sv
//==========================================================================
// Testbench for the control top: reset timing, ioctl decode, input ports
// Inputs change on the rising edge and outputs are sampled on the falling edge
// Random stimulus from a fixed seed, checked against a local model
// Stops at the first mismatch or timeout
//==========================================================================

`timescale 1ns/1ps

module tb_mcr3_control;

	localparam int HOLD = mcr3_ctrl_pkg::RESET_HOLD_CYCLES;

	logic                             clk_sys = 1'b0;
	logic                             reset;
	logic                             ioctl_download;
	logic                             ioctl_wr;
	logic [7:0]                       ioctl_index;
	logic [24:0]                      ioctl_addr;
	logic [7:0]                       ioctl_dout;
	logic                             reset_request;
	logic                             two_stick_mode;
	logic                             sound_status;
	logic [mcr3_ctrl_pkg::JOY_W-1:0]  joy1;
	logic [mcr3_ctrl_pkg::JOY_W-1:0]  joy2;
	logic [mcr3_ctrl_pkg::JOY_W-1:0]  joy3;
	logic                             game_reset;
	logic                             rom_loading;
	mcr3_ctrl_pkg::game_t             game;
	logic [mcr3_ctrl_pkg::PORT_W-1:0] input0;
	logic [mcr3_ctrl_pkg::PORT_W-1:0] input1;
	logic [mcr3_ctrl_pkg::PORT_W-1:0] input2;
	logic [mcr3_ctrl_pkg::PORT_W-1:0] input3;
	logic [mcr3_ctrl_pkg::PORT_W-1:0] input4;

	// Reference model state
	integer               seed;
	logic [7:0]           m_dip [mcr3_ctrl_pkg::DIP_COUNT];
	mcr3_ctrl_pkg::game_t m_game;
	logic [2:0]           m_gear;
	logic [2:0]           m_fire_q;
	logic [7:0]           exp_port [5];

	mcr3_control_top dut0 (.*);

	always #4 clk_sys = ~clk_sys;

	//==========================================================================
	// Failure reporting and compare tasks
	//==========================================================================
	task automatic stop_run();
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_port(input string name, input logic [mcr3_ctrl_pkg::PORT_W-1:0] exp,
		input logic [mcr3_ctrl_pkg::PORT_W-1:0] act);
		if (act !== exp) begin
			$display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_game(input mcr3_ctrl_pkg::game_t exp, input mcr3_ctrl_pkg::game_t act);
		if (act !== exp) begin
			$display("ERROR at %0t: game expected %0d, got %0d", $time, exp, act);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_window(input int cycles);
		if (cycles < HOLD || cycles > HOLD + 3) begin
			$display("game_reset released after %0d cycles, expected %0d to %0d",
				cycles, HOLD, HOLD + 3);
			stop_run();
		end
	endtask

	//==========================================================================
	// Waits bounded by their own cycle limits
	//==========================================================================
	task automatic wait_game_reset(input logic level, input int limit, output int cycles);
		cycles = 0;
		while (game_reset !== level) begin
			if (cycles >= limit) begin
				$display("Timed out waiting for game_reset to go %0b", level);
				stop_run();
			end else begin
				@(negedge clk_sys);
				cycles++;
			end
		end
	endtask

	task automatic wait_rom_loading(input logic level, input int limit);
		int cycles;
		cycles = 0;
		while (rom_loading !== level) begin
			if (cycles >= limit) begin
				$display("Timed out waiting for rom_loading to go %0b", level);
				stop_run();
			end else begin
				@(negedge clk_sys);
				cycles++;
			end
		end
	endtask

	//==========================================================================
	// Port model with active-high fields before inversion
	//==========================================================================
	function automatic mcr3_ctrl_pkg::game_t code_to_game(input logic [7:0] code);
		if (code == 8'd0) return mcr3_ctrl_pkg::GAME_RAMPAGE;
		if (code == 8'd1) return mcr3_ctrl_pkg::GAME_SARGE;
		if (code == 8'd2) return mcr3_ctrl_pkg::GAME_POWERDRIVE;
		return mcr3_ctrl_pkg::GAME_OTHER;
	endfunction

	function automatic logic [7:0] rampage_bits(input logic [9:0] j);
		rampage_bits = 8'h00;
		rampage_bits[5] = j[mcr3_ctrl_pkg::JOY_FIRE_B];
		rampage_bits[4] = j[mcr3_ctrl_pkg::JOY_FIRE_A];
		rampage_bits[3] = j[mcr3_ctrl_pkg::JOY_LEFT];
		rampage_bits[2] = j[mcr3_ctrl_pkg::JOY_DOWN];
		rampage_bits[1] = j[mcr3_ctrl_pkg::JOY_RIGHT];
		rampage_bits[0] = j[mcr3_ctrl_pkg::JOY_UP];
	endfunction

	function automatic logic [7:0] sarge_bits(input logic [9:0] j, input logic mode);
		logic up;
		logic down;
		logic left;
		logic right;
		up    = j[mcr3_ctrl_pkg::JOY_UP];
		down  = j[mcr3_ctrl_pkg::JOY_DOWN];
		left  = j[mcr3_ctrl_pkg::JOY_LEFT];
		right = j[mcr3_ctrl_pkg::JOY_RIGHT];
		sarge_bits[7] = j[mcr3_ctrl_pkg::JOY_FIRE_D];
		sarge_bits[6] = j[mcr3_ctrl_pkg::JOY_FIRE_D];
		sarge_bits[5] = j[mcr3_ctrl_pkg::JOY_FIRE_A];
		sarge_bits[4] = j[mcr3_ctrl_pkg::JOY_FIRE_A];
		sarge_bits[3] = mode ? (down | right) : j[mcr3_ctrl_pkg::JOY_FIRE_B];
		sarge_bits[2] = mode ? (up | left) : j[mcr3_ctrl_pkg::JOY_FIRE_C];
		sarge_bits[1] = mode ? (down | left) : down;
		sarge_bits[0] = mode ? (up | right) : up;
	endfunction

	function automatic logic [3:0] drive_bits(input logic [9:0] j, input logic g);
		drive_bits = {j[mcr3_ctrl_pkg::JOY_FIRE_B], j[mcr3_ctrl_pkg::JOY_FIRE_A], g,
			j[mcr3_ctrl_pkg::JOY_FIRE_C]};
	endfunction

	task automatic compute_ports();
		logic [7:0] hi [5];
		for (int k = 0; k < 5; k++) begin
			hi[k] = 8'h00;
		end
		if (m_game != mcr3_ctrl_pkg::GAME_OTHER) begin
			hi[0][5] = m_dip[1][0];
			hi[0][1] = joy2[mcr3_ctrl_pkg::JOY_COIN];
			hi[0][0] = joy1[mcr3_ctrl_pkg::JOY_COIN];
		end
		case (m_game)
			mcr3_ctrl_pkg::GAME_RAMPAGE: begin
				hi[1] = rampage_bits(joy1);
				hi[2] = rampage_bits(joy2);
				hi[4] = rampage_bits(joy3);
				hi[4][7] = sound_status;
			end
			mcr3_ctrl_pkg::GAME_SARGE: begin
				hi[0][3] = joy2[mcr3_ctrl_pkg::JOY_START];
				hi[0][2] = joy1[mcr3_ctrl_pkg::JOY_START];
				hi[1] = sarge_bits(joy1, two_stick_mode);
				hi[2] = sarge_bits(joy2, two_stick_mode);
			end
			mcr3_ctrl_pkg::GAME_POWERDRIVE: begin
				hi[0][2] = joy3[mcr3_ctrl_pkg::JOY_COIN];
				hi[1] = {drive_bits(joy2, m_gear[1]), drive_bits(joy1, m_gear[0])};
				hi[2] = {sound_status, 3'b000, drive_bits(joy3, m_gear[2])};
			end
			default: begin
			end
		endcase
		for (int k = 0; k < 5; k++) begin
			exp_port[k] = ~hi[k];
		end
		exp_port[3] = m_dip[0];
	endtask

	task automatic check_ports();
		compute_ports();
		check_port("input0", exp_port[0], input0);
		check_port("input1", exp_port[1], input1);
		check_port("input2", exp_port[2], input2);
		check_port("input3", exp_port[3], input3);
		check_port("input4", exp_port[4], input4);
	endtask

	//==========================================================================
	// Stimulus tasks
	//==========================================================================
	// Single ioctl write, then sample two edges after the strobe
	task automatic ioctl_write(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_wr       <= 1'b1;
		ioctl_index    <= index;
		ioctl_addr     <= addr;
		ioctl_dout     <= data;
		@(posedge clk_sys);
		ioctl_wr       <= 1'b0;
		ioctl_download <= 1'b0;
		if (index == mcr3_ctrl_pkg::IDX_GAME) begin
			m_game = code_to_game(data);
		end else if (index == mcr3_ctrl_pkg::IDX_DIP && addr < mcr3_ctrl_pkg::DIP_COUNT) begin
			m_dip[addr] = data;
		end
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic drive_random_joys(input logic mode);
		logic [31:0] r;
		@(posedge clk_sys);
		r = $random(seed);
		joy1           <= r[9:0];
		joy2           <= r[19:10];
		joy3           <= r[29:20];
		sound_status   <= r[30];
		two_stick_mode <= mode;
	endtask

	task automatic clear_joys();
		@(posedge clk_sys);
		joy1 <= '0;
		joy2 <= '0;
		joy3 <= '0;
	endtask

	// Hold reset_request, then time the release back to run
	task automatic request_reset(input int hold);
		int n;
		@(posedge clk_sys);
		reset_request <= 1'b1;
		wait_game_reset(1'b1, 4, n);
		repeat (hold) begin
			@(negedge clk_sys);
			check_bit("game_reset", 1'b1, game_reset);
		end
		m_gear   = 3'b000;
		m_fire_q = 3'b000;
		check_ports();
		@(posedge clk_sys);
		reset_request <= 1'b0;
		@(negedge clk_sys);
		wait_game_reset(1'b0, HOLD + 16, n);
		check_window(n);
	endtask

	//==========================================================================
	// Main sequence
	//==========================================================================
	initial begin
		int          n;
		logic [31:0] r;
		logic [2:0]  fire;
		seed           = 32'hb214_bb5a;
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_addr     = '0;
		ioctl_dout     = 8'd0;
		reset_request  = 1'b0;
		two_stick_mode = 1'b0;
		sound_status   = 1'b0;
		joy1           = '0;
		joy2           = '0;
		joy3           = '0;
		m_game         = mcr3_ctrl_pkg::GAME_RAMPAGE;
		m_gear         = 3'b000;
		m_fire_q       = 3'b000;
		for (int k = 0; k < mcr3_ctrl_pkg::DIP_COUNT; k++) begin
			m_dip[k] = 8'hff;
		end
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;

		// No ROM yet, game stays in reset
		repeat (20) begin
			@(negedge clk_sys);
			check_bit("game_reset", 1'b1, game_reset);
			check_bit("rom_loading", 1'b0, rom_loading);
		end
		check_game(m_game, game);
		check_ports();

		// ROM download with a few random data strobes
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index    <= mcr3_ctrl_pkg::IDX_ROM;
		wait_rom_loading(1'b1, 4);
		repeat (16) begin
			@(posedge clk_sys);
			r = $random(seed);
			ioctl_wr   <= r[0];
			ioctl_addr <= {9'd0, r[23:8]};
			ioctl_dout <= r[31:24];
		end
		@(posedge clk_sys);
		ioctl_wr       <= 1'b0;
		ioctl_download <= 1'b0;
		@(negedge clk_sys);
		wait_game_reset(1'b0, HOLD + 16, n);
		check_window(n);
		check_bit("rom_loading", 1'b0, rom_loading);

		request_reset(12);

		// Random DIP and game-code writes, then every idle game code
		repeat (32) begin
			r = $random(seed);
			if (r[0]) begin
				ioctl_write(mcr3_ctrl_pkg::IDX_DIP, r[11:8], r[23:16]);
			end else begin
				ioctl_write(mcr3_ctrl_pkg::IDX_GAME, '0, r[15:8] % 8'd6);
			end
			check_game(m_game, game);
			check_ports();
		end
		for (int code = 3; code < 6; code++) begin
			// Random sticks so the idle ports differ from every game layout
			drive_random_joys(1'b0);
			ioctl_write(mcr3_ctrl_pkg::IDX_GAME, '0, code);
			check_game(mcr3_ctrl_pkg::GAME_OTHER, game);
			check_ports();
		end

		// Rampage, then Sarge in both stick modes
		ioctl_write(mcr3_ctrl_pkg::IDX_GAME, '0, 8'd0);
		check_game(mcr3_ctrl_pkg::GAME_RAMPAGE, game);
		repeat (40) begin
			r = $random(seed);
			drive_random_joys(r[0]);
			@(posedge clk_sys);
			@(negedge clk_sys);
			check_ports();
		end
		ioctl_write(mcr3_ctrl_pkg::IDX_GAME, '0, 8'd1);
		check_game(mcr3_ctrl_pkg::GAME_SARGE, game);
		for (int mode = 0; mode < 2; mode++) begin
			repeat (40) begin
				drive_random_joys(mode[0]);
				@(posedge clk_sys);
				@(negedge clk_sys);
				check_ports();
			end
		end

		// Power Drive gears start from a cleared state
		ioctl_write(mcr3_ctrl_pkg::IDX_GAME, '0, 8'd2);
		check_game(mcr3_ctrl_pkg::GAME_POWERDRIVE, game);
		clear_joys();
		request_reset(8);
		check_ports();
		repeat (60) begin
			r = $random(seed);
			drive_random_joys(r[0]);
			@(posedge clk_sys);
			fire     = {joy3[mcr3_ctrl_pkg::JOY_FIRE_D], joy2[mcr3_ctrl_pkg::JOY_FIRE_D],
				joy1[mcr3_ctrl_pkg::JOY_FIRE_D]};
			m_gear   = m_gear ^ (fire & ~m_fire_q);
			m_fire_q = fire;
			@(negedge clk_sys);
			check_ports();
		end
		clear_joys();
		request_reset(10);
		check_bit("gear 0", 1'b1, input1[1]);
		check_bit("gear 1", 1'b1, input1[5]);
		check_bit("gear 2", 1'b1, input2[1]);
		check_ports();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: filelist.f
logic/mcr3_ctrl_pkg.sv
logic/download_decoder.sv
logic/reset_sequencer.sv
logic/reset_hold_timer.sv
logic/gear_shifter.sv
logic/input_port_mux.sv
logic/mcr3_control_top.sv
test/tb_mcr3_control.sv
